/* irq_pkg.sv */
/*
 * Interrupt word layout of the core: field constants and the two views
 * (field by field, flat vector) of the 32-bit interrupt word.
 */
package irq_pkg;

  localparam int IRQ_WIDTH    = 32;
  localparam int FAST_IRQ_NUM = 15;
  localparam int TIMER_NUM    = 4;
  // dma done, spi, spi flash and eight gpio lines
  localparam int FAST_SRC_NUM = 11;

  typedef struct packed {
    logic                    rsvd_31;
    logic [FAST_IRQ_NUM-1:0] fast;
    logic [3:0]              rsvd_15_12;
    logic                    ext;
    logic [2:0]              rsvd_10_8;
    logic                    timer0;
    logic [2:0]              rsvd_6_4;
    logic                    sw;
    logic [2:0]              rsvd_2_0;
  } irq_fields_t;

  // built per field, handed to the core as a flat word
  typedef union packed {
    irq_fields_t          fields;
    logic [IRQ_WIDTH-1:0] word;
  } irq_word_u;

endpackage

/* power_pkg.sv */
/*
 * Power domain definitions: domain indices, power commands, command queue
 * sizing, per-domain control word and sequencer state codes.
 */
package power_pkg;

  localparam int NUM_DOMAINS = 4;
  localparam int DOM_IDX_W   = 2;

  localparam logic [DOM_IDX_W-1:0] DOM_CPU    = 2'd0;
  localparam logic [DOM_IDX_W-1:0] DOM_PERIPH = 2'd1;
  localparam logic [DOM_IDX_W-1:0] DOM_RAM0   = 2'd2;
  localparam logic [DOM_IDX_W-1:0] DOM_RAM1   = 2'd3;

  typedef struct packed {
    logic [DOM_IDX_W-1:0] domain;
    logic                 pwr_on;
  } pwr_cmd_t;

  // issued on a wake event from sleep
  localparam pwr_cmd_t CMD_CPU_WAKE = '{domain: DOM_CPU, pwr_on: 1'b1};

  localparam int CMD_FIFO_DEPTH = 4;
  localparam int CMD_PTR_W      = $clog2(CMD_FIFO_DEPTH);
  localparam int CMD_CNT_W      = $clog2(CMD_FIFO_DEPTH + 1);

  // all lines active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
  } pwr_ctrl_t;

  localparam pwr_ctrl_t PWR_CTRL_ON = '1;

  localparam int SEQ_STATE_W = 4;

  localparam logic [SEQ_STATE_W-1:0] SEQ_IDLE     = 4'd0;
  localparam logic [SEQ_STATE_W-1:0] SEQ_OFF_CLK  = 4'd1;
  localparam logic [SEQ_STATE_W-1:0] SEQ_OFF_ISO  = 4'd2;
  localparam logic [SEQ_STATE_W-1:0] SEQ_OFF_RST  = 4'd3;
  localparam logic [SEQ_STATE_W-1:0] SEQ_OFF_PWR  = 4'd4;
  localparam logic [SEQ_STATE_W-1:0] SEQ_OFF_WAIT = 4'd5;
  localparam logic [SEQ_STATE_W-1:0] SEQ_ON_WAIT  = 4'd6;
  localparam logic [SEQ_STATE_W-1:0] SEQ_ON_RST   = 4'd7;
  localparam logic [SEQ_STATE_W-1:0] SEQ_ON_ISO   = 4'd8;
  localparam logic [SEQ_STATE_W-1:0] SEQ_ON_CLK   = 4'd9;

endpackage

/* pwr_cmd_if.sv */
/*
 * Power command queue link: source pushes, FIFO stores, sequencer pops.
 */
`timescale 1ns/10ps

interface pwr_cmd_if
  import power_pkg::*;
();

  logic     push;
  pwr_cmd_t wr_cmd;
  logic     full;
  logic     pop;
  pwr_cmd_t rd_cmd;
  logic     empty;

  modport source (output push, output wr_cmd, input full);
  modport fifo (input push, input wr_cmd, input pop, output full, output rd_cmd, output empty);
  modport sink (output pop, input rd_cmd, input empty);

endinterface

/* pwr_cmd_source.sv */
/*
 * Collects interrupt sources into the core interrupt word and feeds power
 * commands to the queue: wake events first, then external requests.
 */
`timescale 1ns/10ps

module pwr_cmd_source
  import irq_pkg::*;
  import power_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    sw_irq_i,
  input  logic                    ext_irq_i,
  input  logic [TIMER_NUM-1:0]    timer_irq_i,
  input  logic [FAST_SRC_NUM-1:0] fast_src_i,
  input  logic                    core_sleep_i,
  input  logic                    cmd_valid_i,
  input  pwr_cmd_t                cmd_i,
  output logic [IRQ_WIDTH-1:0]    intr_o,
  output logic                    cmd_drop_o,
  pwr_cmd_if.source               cmd_if
);

  irq_word_u irq_d;
  logic      wake_evt;
  logic      wake_push;
  logic      pend_vld;
  pwr_cmd_t  pend_cmd;
  logic      pend_push;
  logic      pend_free;

  always_comb begin
    irq_d = '0;
    irq_d.fields.sw = sw_irq_i;
    irq_d.fields.timer0 = timer_irq_i[0];
    irq_d.fields.ext = ext_irq_i;
    // timers 1..3 at the bottom, top fast bit unused
    irq_d.fields.fast = {1'b0, fast_src_i, timer_irq_i[TIMER_NUM-1:1]};
  end

  // first interrupt while the core sleeps
  assign wake_evt  = core_sleep_i && (intr_o == '0) && (irq_d.word != '0);
  assign wake_push = wake_evt && !cmd_if.full;

  assign pend_push = pend_vld && !wake_push && !cmd_if.full;
  assign pend_free = !pend_vld || pend_push;

  assign cmd_if.push   = wake_push || pend_push;
  assign cmd_if.wr_cmd = wake_push ? CMD_CPU_WAKE : pend_cmd;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      intr_o     <= '0;
      pend_vld   <= 1'b0;
      cmd_drop_o <= 1'b0;
    end else begin
      intr_o     <= irq_d.word;
      cmd_drop_o <= cmd_valid_i && !pend_free;
      if (cmd_valid_i && pend_free) begin
        pend_vld <= 1'b1;
      end else if (pend_push) begin
        pend_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && pend_free) begin
      pend_cmd <= cmd_i;
    end
  end

endmodule

/* pwr_cmd_fifo.sv */
/*
 * Small circular buffer of power commands between source and sequencer.
 */
`timescale 1ns/10ps

module pwr_cmd_fifo
  import power_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  pwr_cmd_if.fifo q_if
);

  pwr_cmd_t             mem [CMD_FIFO_DEPTH];
  logic [CMD_PTR_W-1:0] wr_ptr;
  logic [CMD_PTR_W-1:0] rd_ptr;
  logic [CMD_CNT_W-1:0] count;
  logic                 do_push;
  logic                 do_pop;

  assign do_push = q_if.push && !q_if.full;
  assign do_pop  = q_if.pop && !q_if.empty;

  assign q_if.full   = (count == CMD_CNT_W'(CMD_FIFO_DEPTH));
  assign q_if.empty  = (count == '0);
  assign q_if.rd_cmd = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= q_if.wr_cmd;
    end
  end

endmodule

/* domain_sequencer.sv */
/*
 * Runs one power-off or power-on sequence at a time on the control lines
 * of the addressed domain, waiting on the power switch acknowledge.
 */
`timescale 1ns/10ps

module domain_sequencer
  import power_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [NUM_DOMAINS-1:0] pwrgate_ack_n_i,
  output pwr_ctrl_t              pwr_ctrl_o [NUM_DOMAINS],
  output logic                   seq_idle_o,
  pwr_cmd_if.sink                cmd_if
);

  logic [SEQ_STATE_W-1:0] state_q;
  pwr_cmd_t               cur_cmd;
  logic                   ack_n;

  assign ack_n      = pwrgate_ack_n_i[cur_cmd.domain];
  assign seq_idle_o = (state_q == SEQ_IDLE);
  assign cmd_if.pop = (state_q == SEQ_IDLE) && !cmd_if.empty;

  always_ff @(posedge clk_i) begin
    if (cmd_if.pop) begin
      cur_cmd <= cmd_if.rd_cmd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SEQ_IDLE;
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        pwr_ctrl_o[d] <= PWR_CTRL_ON;
      end
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (cmd_if.pop) begin
            state_q <= cmd_if.rd_cmd.pwr_on ? SEQ_ON_WAIT : SEQ_OFF_CLK;
          end
        end
        // off: clock, isolation, reset, then the switch
        SEQ_OFF_CLK: begin
          pwr_ctrl_o[cur_cmd.domain].clkgate_en_n <= 1'b0;
          state_q <= SEQ_OFF_ISO;
        end
        SEQ_OFF_ISO: begin
          pwr_ctrl_o[cur_cmd.domain].isogate_en_n <= 1'b0;
          state_q <= SEQ_OFF_RST;
        end
        SEQ_OFF_RST: begin
          pwr_ctrl_o[cur_cmd.domain].rst_n <= 1'b0;
          state_q <= SEQ_OFF_PWR;
        end
        SEQ_OFF_PWR: begin
          pwr_ctrl_o[cur_cmd.domain].pwrgate_en_n <= 1'b0;
          state_q <= SEQ_OFF_WAIT;
        end
        SEQ_OFF_WAIT: begin
          if (!ack_n) begin
            state_q <= SEQ_IDLE;
          end
        end
        // switch on first, domain stays in reset until acknowledged
        SEQ_ON_WAIT: begin
          pwr_ctrl_o[cur_cmd.domain].pwrgate_en_n <= 1'b1;
          if (ack_n) begin
            state_q <= SEQ_ON_RST;
          end
        end
        SEQ_ON_RST: begin
          pwr_ctrl_o[cur_cmd.domain].rst_n <= 1'b1;
          state_q <= SEQ_ON_ISO;
        end
        SEQ_ON_ISO: begin
          pwr_ctrl_o[cur_cmd.domain].isogate_en_n <= 1'b1;
          state_q <= SEQ_ON_CLK;
        end
        SEQ_ON_CLK: begin
          pwr_ctrl_o[cur_cmd.domain].clkgate_en_n <= 1'b1;
          state_q <= SEQ_IDLE;
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

endmodule

/* ao_power_ctrl.sv */
/*
 * Always-on power control top: interrupt collection, power command queue
 * and domain sequencing, with the domain lines unrolled per signal.
 */
`timescale 1ns/10ps

module ao_power_ctrl
  import irq_pkg::*;
  import power_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    sw_irq_i,
  input  logic                    ext_irq_i,
  input  logic [TIMER_NUM-1:0]    timer_irq_i,
  input  logic [FAST_SRC_NUM-1:0] fast_src_i,
  input  logic                    core_sleep_i,
  input  logic                    cmd_valid_i,
  input  logic [DOM_IDX_W-1:0]    cmd_domain_i,
  input  logic                    cmd_on_i,
  input  logic [NUM_DOMAINS-1:0]  pwrgate_ack_n_i,
  output logic [IRQ_WIDTH-1:0]    intr_o,
  output logic                    cmd_drop_o,
  output logic                    seq_idle_o,
  output logic [NUM_DOMAINS-1:0]  pwrgate_en_n_o,
  output logic [NUM_DOMAINS-1:0]  isogate_en_n_o,
  output logic [NUM_DOMAINS-1:0]  rst_n_o,
  output logic [NUM_DOMAINS-1:0]  clkgate_en_n_o
);

  pwr_cmd_t  ext_cmd;
  pwr_ctrl_t pwr_ctrl [NUM_DOMAINS];

  pwr_cmd_if cmd_q ();

  assign ext_cmd = '{domain: cmd_domain_i, pwr_on: cmd_on_i};

  pwr_cmd_source i_pwr_cmd_source (
    .clk_i,
    .rst_n_i,
    .sw_irq_i,
    .ext_irq_i,
    .timer_irq_i,
    .fast_src_i,
    .core_sleep_i,
    .cmd_valid_i,
    .cmd_i      (ext_cmd),
    .intr_o,
    .cmd_drop_o,
    .cmd_if     (cmd_q.source)
  );

  pwr_cmd_fifo i_pwr_cmd_fifo (
    .clk_i,
    .rst_n_i,
    .q_if   (cmd_q.fifo)
  );

  domain_sequencer i_domain_sequencer (
    .clk_i,
    .rst_n_i,
    .pwrgate_ack_n_i,
    .pwr_ctrl_o     (pwr_ctrl),
    .seq_idle_o,
    .cmd_if         (cmd_q.sink)
  );

  // one bit per domain for the switch cells and isolation
  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_dom_lines
    assign pwrgate_en_n_o[d] = pwr_ctrl[d].pwrgate_en_n;
    assign isogate_en_n_o[d] = pwr_ctrl[d].isogate_en_n;
    assign rst_n_o[d]        = pwr_ctrl[d].rst_n;
    assign clkgate_en_n_o[d] = pwr_ctrl[d].clkgate_en_n;
  end

endmodule

/* tb_ao_power_ctrl.sv */
/*
 * Testbench for the always-on power control top. Covers the interrupt word
 * layout, per-domain power sequencing, wake from sleep and queue back-pressure.
 */
`timescale 1ns/10ps

module tb_ao_power_ctrl
  import irq_pkg::*;
  import power_pkg::*;
();

  typedef struct packed {
    logic                    is_cmd;
    logic                    sw;
    logic                    ext;
    logic [TIMER_NUM-1:0]    timer;
    logic [FAST_SRC_NUM-1:0] fast;
    logic [IRQ_WIDTH-1:0]    exp_intr;
    logic [DOM_IDX_W-1:0]    dom;
    logic                    on;
    logic [3:0]              exp_lines;
  } row_t;

  localparam int NUM_ROWS = 14;

  // each row is an irq row (sources, intr_o) or a command row (domain, on bit, final lines)
  localparam row_t ROWS [NUM_ROWS] = '{
    '{1'b0, 1'b1, 1'b0, 4'h0, 11'h000, 32'h0000_0008, 2'd0, 1'b0, 4'h0},
    '{1'b0, 1'b0, 1'b0, 4'h1, 11'h000, 32'h0000_0080, 2'd0, 1'b0, 4'h0},
    '{1'b0, 1'b0, 1'b1, 4'h0, 11'h000, 32'h0000_0800, 2'd0, 1'b0, 4'h0},
    '{1'b0, 1'b0, 1'b0, 4'he, 11'h000, 32'h0007_0000, 2'd0, 1'b0, 4'h0},
    '{1'b0, 1'b0, 1'b0, 4'h0, 11'h401, 32'h2008_0000, 2'd0, 1'b0, 4'h0},
    '{1'b0, 1'b1, 1'b1, 4'hf, 11'h7ff, 32'h3fff_0888, 2'd0, 1'b0, 4'h0},
    '{1'b0, 1'b0, 1'b0, 4'h0, 11'h000, 32'h0000_0000, 2'd0, 1'b0, 4'h0},
    '{1'b1, 1'b0, 1'b0, 4'h0, 11'h000, 32'h0000_0000, 2'd0, 1'b0, 4'h0},
    '{1'b1, 1'b0, 1'b0, 4'h0, 11'h000, 32'h0000_0000, 2'd1, 1'b0, 4'h0},
    '{1'b1, 1'b0, 1'b0, 4'h0, 11'h000, 32'h0000_0000, 2'd2, 1'b0, 4'h0},
    '{1'b1, 1'b0, 1'b0, 4'h0, 11'h000, 32'h0000_0000, 2'd3, 1'b0, 4'h0},
    '{1'b1, 1'b0, 1'b0, 4'h0, 11'h000, 32'h0000_0000, 2'd1, 1'b1, 4'hf},
    '{1'b1, 1'b0, 1'b0, 4'h0, 11'h000, 32'h0000_0000, 2'd2, 1'b1, 4'hf},
    '{1'b1, 1'b0, 1'b0, 4'h0, 11'h000, 32'h0000_0000, 2'd3, 1'b1, 4'hf}
  };

  logic clk_i, rst_n_i, sw_irq_i, ext_irq_i, core_sleep_i, cmd_valid_i, cmd_on_i;
  logic [TIMER_NUM-1:0]    timer_irq_i;
  logic [FAST_SRC_NUM-1:0] fast_src_i;
  logic [DOM_IDX_W-1:0]    cmd_domain_i;
  logic [IRQ_WIDTH-1:0]    intr_o;
  logic                    cmd_drop_o, seq_idle_o;
  logic [NUM_DOMAINS-1:0]  pwrgate_ack_n_i, pwrgate_en_n_o, isogate_en_n_o;
  logic [NUM_DOMAINS-1:0]  rst_n_o, clkgate_en_n_o, ack_hold, dom_state;
  logic [3:0]              prev_lines;
  logic [31:0]             rng;
  int                      ack_cnt [NUM_DOMAINS];

  ao_power_ctrl i_ao_power_ctrl (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // ack_n follows the switch enable 1 to 4 cycles later
  initial begin
    rng = 32'h4710;
    pwrgate_ack_n_i <= '1;
    forever begin
      @(posedge clk_i);
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (!rst_n_i || ack_hold[d] || pwrgate_ack_n_i[d] == pwrgate_en_n_o[d]) begin
          ack_cnt[d] = 0;
        end else begin
          if (ack_cnt[d] == 0) begin
            rng = xorshift(rng);
            ack_cnt[d] = 1 + int'(rng[1:0]);
          end
          if (ack_cnt[d] == 1) begin
            pwrgate_ack_n_i[d] <= pwrgate_en_n_o[d];
            ack_cnt[d] = 0;
          end else begin
            ack_cnt[d] = ack_cnt[d] - 1;
          end
        end
      end
    end
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  // bits ordered from switch to clock so every step moves one bit
  function automatic logic [3:0] dom_lines(input logic [DOM_IDX_W-1:0] d);
    return {pwrgate_en_n_o[d], rst_n_o[d], isogate_en_n_o[d], clkgate_en_n_o[d]};
  endfunction

  task automatic check_lines(input logic [NUM_DOMAINS-1:0] mask);
    check("pwrgate_en_n_o", 32'(pwrgate_en_n_o & mask), 32'(dom_state & mask));
    check("isogate_en_n_o", 32'(isogate_en_n_o & mask), 32'(dom_state & mask));
    check("rst_n_o", 32'(rst_n_o & mask), 32'(dom_state & mask));
    check("clkgate_en_n_o", 32'(clkgate_en_n_o & mask), 32'(dom_state & mask));
  endtask

  task automatic check_step(input logic [DOM_IDX_W-1:0] d, input logic on);
    logic [3:0] lines;
    logic [3:0] next;
    lines = dom_lines(d);
    next = on ? {1'b1, prev_lines[3:1]} : {prev_lines[2:0], 1'b0};
    check($sformatf("dom%0d pwr/rst/iso/clk", d), 32'(lines),
          32'((lines == prev_lines) ? prev_lines : next));
    // reset is released only with the switch acknowledged on
    check("rst_n_o", 32'(rst_n_o[d] & ~pwrgate_ack_n_i[d]), 32'd0);
    check_lines(~(4'b0001 << d));
    prev_lines = lines;
  endtask

  task automatic drive_cmd(input logic [DOM_IDX_W-1:0] d, input logic on);
    @(posedge clk_i);
    cmd_valid_i  <= 1'b1;
    cmd_domain_i <= d;
    cmd_on_i     <= on;
  endtask

  task automatic send_cmd(input logic [DOM_IDX_W-1:0] d, input logic on);
    drive_cmd(d, on);
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic run_sequence(input logic [DOM_IDX_W-1:0] d, input logic on,
                              input logic [3:0] exp_lines);
    int n;
    prev_lines = dom_lines(d);
    n = 0;
    do begin
      @(negedge clk_i);
      check_step(d, on);
      n++;
    end while (seq_idle_o && n < 10);
    if (seq_idle_o) fail_run("timeout waiting for the sequencer to start");
    n = 0;
    while (!seq_idle_o && n < 40) begin
      @(negedge clk_i);
      check_step(d, on);
      n++;
    end
    if (!seq_idle_o) fail_run("timeout waiting for the sequencer to return to idle");
    check($sformatf("dom%0d pwr/rst/iso/clk", d), 32'(dom_lines(d)), 32'(exp_lines));
    dom_state[d] = on;
    check_lines('1);
  endtask

  initial begin
    int n;
    rst_n_i      <= 1'b0;
    sw_irq_i     <= 1'b0;
    ext_irq_i    <= 1'b0;
    timer_irq_i  <= '0;
    fast_src_i   <= '0;
    core_sleep_i <= 1'b0;
    cmd_valid_i  <= 1'b0;
    cmd_domain_i <= '0;
    cmd_on_i     <= 1'b0;
    ack_hold     = '0;
    dom_state    = '1;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_lines('1);
    check("seq_idle_o", 32'(seq_idle_o), 32'd1);
    check("cmd_drop_o", 32'(cmd_drop_o), 32'd0);
    check("intr_o", intr_o, 32'd0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      if (ROWS[i].is_cmd) begin
        send_cmd(ROWS[i].dom, ROWS[i].on);
        run_sequence(ROWS[i].dom, ROWS[i].on, ROWS[i].exp_lines);
      end else begin
        @(posedge clk_i);
        sw_irq_i    <= ROWS[i].sw;
        ext_irq_i   <= ROWS[i].ext;
        timer_irq_i <= ROWS[i].timer;
        fast_src_i  <= ROWS[i].fast;
        @(posedge clk_i);
        @(negedge clk_i);
        check("intr_o", intr_o, ROWS[i].exp_intr);
      end
    end

    // an interrupt while awake must not restart the powered-off cpu
    @(posedge clk_i);
    ext_irq_i <= 1'b1;
    repeat (8) begin
      @(negedge clk_i);
      check("seq_idle_o", 32'(seq_idle_o), 32'd1);
      check_lines('1);
    end
    @(posedge clk_i);
    ext_irq_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    check("intr_o", intr_o, 32'd0);
    @(posedge clk_i);
    core_sleep_i <= 1'b1;
    timer_irq_i  <= 4'b0100;
    run_sequence(DOM_CPU, 1'b1, 4'hf);
    @(posedge clk_i);
    core_sleep_i <= 1'b0;
    timer_irq_i  <= '0;

    // queue backs up behind the held-off ram0 switch
    ack_hold[DOM_RAM0] = 1'b1;
    send_cmd(DOM_RAM0, 1'b0);
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (pwrgate_en_n_o[DOM_RAM0] && n < 20);
    if (pwrgate_en_n_o[DOM_RAM0]) fail_run("timeout waiting for the ram0 switch to open");
    drive_cmd(DOM_PERIPH, 1'b0);
    drive_cmd(DOM_RAM1, 1'b0);
    drive_cmd(DOM_PERIPH, 1'b1);
    drive_cmd(DOM_RAM1, 1'b1);
    drive_cmd(DOM_CPU, 1'b0);
    drive_cmd(DOM_RAM1, 1'b0);
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!cmd_drop_o && n < 4);
    if (!cmd_drop_o) fail_run("timeout waiting for the drop pulse of the last command");
    @(negedge clk_i);
    check("cmd_drop_o", 32'(cmd_drop_o), 32'd0);
    check("seq_idle_o", 32'(seq_idle_o), 32'd0);
    ack_hold[DOM_RAM0] = 1'b0;
    run_sequence(DOM_RAM0, 1'b0, 4'h0);
    run_sequence(DOM_PERIPH, 1'b0, 4'h0);
    run_sequence(DOM_RAM1, 1'b0, 4'h0);
    run_sequence(DOM_PERIPH, 1'b1, 4'hf);
    run_sequence(DOM_RAM1, 1'b1, 4'hf);
    run_sequence(DOM_CPU, 1'b0, 4'h0);
    repeat (6) begin
      @(negedge clk_i);
      check("seq_idle_o", 32'(seq_idle_o), 32'd1);
      check_lines('1);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

/* src.f */
irq_pkg.sv
power_pkg.sv
pwr_cmd_if.sv
pwr_cmd_source.sv
pwr_cmd_fifo.sv
domain_sequencer.sv
ao_power_ctrl.sv
tb_ao_power_ctrl.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
  && verilator --binary -f src.f --top-module tb_ao_power_ctrl -o sim_tb \
  && ./obj_dir/sim_tb 2>&1 | tee /dev/stderr | grep -qF "All tests passed!" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
